// ==== filelist.f ====
+incdir+.
mem_port_pkg.sv
mem_bus_pkg.sv
mem_arbiter.sv
mem_bank_4c.sv
mem_rsp_router.sv
cache_to_mem.sv
cache_to_mem_checker.sv
tb_cache_to_mem.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds and runs the cache_to_mem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_cache_to_mem -f filelist.f -o sim_tb

# the simulation exits non-zero on failure, the search below decides the result
out=$(./obj_dir/sim_tb 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "All checks passed"; then
    exit 0
else
    exit 1
fi

// ==== tb_cache_to_mem.sv ====
// testbench for cache_to_mem, inputs driven on the falling edge, outputs sampled there too
// a read accepted at edge N is expected between edges N+3 and N+4, taken by the cache at N+4
// reference memory ignores address bits above MEM_DEPTH_W, like the bank
`timescale 1ns/1ps
`include "mem_macros.svh"

module tb_cache_to_mem;

    typedef struct packed {
        mem_port_pkg::port_id_e port;
        logic                   write;
        // next entry is raised in the same cycle as this one
        logic                   pair;
        logic [`MEM_ADDR_W-1:0] addr;
        logic [`MEM_DATA_W-1:0] data;
        // idle cycles after acceptance
        logic [3:0]             hold;
    } stim_t;

    typedef struct packed {
        mem_port_pkg::port_id_e owner;
        logic [`MEM_DATA_W-1:0] data;
        logic [31:0]            due;
    } exp_t;

    localparam int NUM_STIM = 13;
    localparam int ACCEPT_TIMEOUT = 20;
    localparam logic [`MEM_ADDR_W-1:0] WIN_BASE = 16'h0200;

    logic                    clk;
    logic                    rst_n;
    logic                    i_req_valid;
    logic                    i_req_ready;
    logic [`MEM_ADDR_W-1:0]  i_addr;
    logic                    d_req_valid;
    logic                    d_req_ready;
    mem_bus_pkg::cache_req_t d_req;
    logic                    i_rsp_valid;
    logic                    d_rsp_valid;
    logic [`MEM_DATA_W-1:0]  rsp_data;

    logic [`MEM_DATA_W-1:0] ref_mem [1 << `MEM_DEPTH_W];
    exp_t                   exp_q [$];
    int                     cyc;
    int                     errors;
    logic                   mon_en;
    logic [15:0]            lfsr_state;

    // directed cases: write then read, i fetch, d/i collision, alternating burst, aliasing
    stim_t stim_tbl [NUM_STIM] = '{
        '{mem_port_pkg::PORT_D, 1'b1, 1'b0, 16'h0010, 16'hA5C3, 4'd0},
        '{mem_port_pkg::PORT_D, 1'b0, 1'b0, 16'h0010, 16'h0000, 4'd6},
        '{mem_port_pkg::PORT_D, 1'b1, 1'b0, 16'h0020, 16'h1234, 4'd0},
        '{mem_port_pkg::PORT_I, 1'b0, 1'b0, 16'h0020, 16'h0000, 4'd6},
        '{mem_port_pkg::PORT_D, 1'b1, 1'b0, 16'h0030, 16'hBEEF, 4'd0},
        '{mem_port_pkg::PORT_D, 1'b0, 1'b1, 16'h0010, 16'h0000, 4'd0},
        '{mem_port_pkg::PORT_I, 1'b0, 1'b0, 16'h0030, 16'h0000, 4'd6},
        '{mem_port_pkg::PORT_I, 1'b0, 1'b0, 16'h0010, 16'h0000, 4'd0},
        '{mem_port_pkg::PORT_D, 1'b0, 1'b0, 16'h0020, 16'h0000, 4'd0},
        '{mem_port_pkg::PORT_I, 1'b0, 1'b0, 16'h0030, 16'h0000, 4'd0},
        '{mem_port_pkg::PORT_D, 1'b0, 1'b0, 16'h0030, 16'h0000, 4'd6},
        '{mem_port_pkg::PORT_D, 1'b1, 1'b0, 16'h0410, 16'hC0DE, 4'd0},
        '{mem_port_pkg::PORT_D, 1'b0, 1'b0, 16'h0010, 16'h0000, 4'd6}
    };

    cache_to_mem UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_req_valid (i_req_valid),
        .i_req_ready (i_req_ready),
        .i_addr      (i_addr),
        .d_req_valid (d_req_valid),
        .d_req_ready (d_req_ready),
        .d_req       (d_req),
        .i_rsp_valid (i_rsp_valid),
        .d_rsp_valid (d_rsp_valid),
        .rsp_data    (rsp_data)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic stop_run();
        errors++;
        $display("Checks failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic fail_value(input string msg);
        $display("[FAIL] %0t ns %s", $time, msg);
        stop_run();
    endtask

    task automatic fail_plain(input string msg);
        $display("%s", msg);
        stop_run();
    endtask

    task automatic check_ready(input logic got_i, input logic got_d,
                               input logic exp_i, input logic exp_d);
        if (got_i !== exp_i || got_d !== exp_d) begin
            fail_value($sformatf("ready i=%b d=%b, expected i=%b d=%b",
                                 got_i, got_d, exp_i, exp_d));
        end
    endtask

    task automatic check_rsp(input mem_port_pkg::port_id_e got_owner,
                             input logic [`MEM_DATA_W-1:0] got_data,
                             input mem_port_pkg::port_id_e exp_owner,
                             input logic [`MEM_DATA_W-1:0] exp_data);
        if (got_owner !== exp_owner || got_data !== exp_data) begin
            fail_value($sformatf("response %s %h, expected %s %h",
                                 got_owner.name(), got_data, exp_owner.name(), exp_data));
        end
    endtask

    // galois form, taps for x^16+x^14+x^13+x^11+1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    // one lfsr step per bit taken
    task automatic draw_bits(input int n, output logic [15:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[14:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // preload pattern, every address bit changes the word
    function automatic logic [15:0] fill_word(input logic [15:0] a);
        return (a * 16'h9E37) ^ {a[7:0], a[15:8]};
    endfunction

    // reference model update at acceptance, reads queue their expected response
    task automatic note_accept(input mem_port_pkg::port_id_e owner, input logic write,
                               input logic [`MEM_ADDR_W-1:0] addr,
                               input logic [`MEM_DATA_W-1:0] data);
        exp_t e;
        if (write) begin
            ref_mem[addr[`MEM_DEPTH_W-1:0]] = data;
        end else begin
            e.owner = owner;
            e.data  = ref_mem[addr[`MEM_DEPTH_W-1:0]];
            // accepting edge is cyc+1, valid shows after edge cyc+4
            e.due   = cyc + `MEM_LATENCY;
            exp_q.push_back(e);
        end
    endtask

    task automatic apply_req(input stim_t s);
        if (s.port == mem_port_pkg::PORT_D) begin
            d_req_valid = 1'b1;
            d_req.write = s.write;
            d_req.addr  = s.addr;
            d_req.wdata = s.data;
        end else begin
            i_req_valid = 1'b1;
            i_addr      = s.addr;
        end
    endtask

    // called on a falling edge, returns on a falling edge with both valids low
    task automatic drive_until_accepted();
        int   waited;
        logic take_d;
        logic take_i;
        waited = 0;
        while (i_req_valid || d_req_valid) begin
            if (waited > ACCEPT_TIMEOUT) begin
                fail_plain("a request was not accepted within the timeout");
            end
            #1;
            // data side always ready, instruction side only without a data request
            check_ready(i_req_ready, d_req_ready, !d_req_valid, 1'b1);
            take_d = d_req_valid && d_req_ready;
            take_i = i_req_valid && i_req_ready;
            if (take_d) begin
                note_accept(mem_port_pkg::PORT_D, d_req.write, d_req.addr, d_req.wdata);
            end else if (take_i) begin
                note_accept(mem_port_pkg::PORT_I, 1'b0, i_addr, '0);
            end
            @(posedge clk);
            @(negedge clk);
            if (take_d) begin
                d_req_valid = 1'b0;
            end else if (take_i) begin
                i_req_valid = 1'b0;
            end
            waited++;
        end
    endtask

    task automatic issue(input stim_t s);
        apply_req(s);
        drive_until_accepted();
        repeat (s.hold) @(negedge clk);
    endtask

    // response monitor, one queued read per valid, on its due cycle
    always @(negedge clk) begin
        exp_t                   e;
        mem_port_pkg::port_id_e got;
        if (mon_en) begin
            if (i_rsp_valid && d_rsp_valid) begin
                fail_value("both response valids high");
            end else if (i_rsp_valid || d_rsp_valid) begin
                if (exp_q.size() == 0) begin
                    fail_value("response valid with no read outstanding");
                end
                e   = exp_q.pop_front();
                got = i_rsp_valid ? mem_port_pkg::PORT_I : mem_port_pkg::PORT_D;
                if (cyc != int'(e.due)) begin
                    fail_value($sformatf("response in cycle %0d, expected %0d", cyc, e.due));
                end
                check_rsp(got, rsp_data, e.owner, e.data);
            end else if (exp_q.size() != 0 && int'(exp_q[0].due) <= cyc) begin
                fail_value("expected response did not arrive");
            end
        end
    end

    initial begin
        int          n;
        int          waited;
        stim_t       s;
        logic [15:0] b_port;
        logic [15:0] b_wr;
        logic [15:0] b_addr;
        logic [15:0] b_data;
        logic [15:0] b_hold;
        logic [15:0] waddr;
        clk         = 1'b0;
        rst_n       = 1'b0;
        i_req_valid = 1'b0;
        i_addr      = '0;
        d_req_valid = 1'b0;
        d_req       = '0;
        cyc         = 0;
        errors      = 0;
        mon_en      = 1'b0;
        lfsr_state  = 16'd74;

        // reset, nothing ready and no response
        for (int k = 0; k < 16; k++) begin
            @(posedge clk);
            @(negedge clk);
            check_ready(i_req_ready, d_req_ready, 1'b0, 1'b0);
            if (i_rsp_valid || d_rsp_valid) begin
                fail_value("response valid high during reset");
            end
        end
        rst_n = 1'b1;
        #1;
        check_ready(i_req_ready, d_req_ready, 1'b0, 1'b0);
        @(negedge clk);
        if (i_rsp_valid || d_rsp_valid) begin
            fail_value("response valid high in first cycle after reset");
        end
        mon_en = 1'b1;

        n = 0;
        while (n < NUM_STIM) begin
            apply_req(stim_tbl[n]);
            if (stim_tbl[n].pair) begin
                n++;
                apply_req(stim_tbl[n]);
            end
            drive_until_accepted();
            repeat (stim_tbl[n].hold) @(negedge clk);
            n++;
        end

        // preload the random window so every read has a known word
        for (int a = 0; a < 64; a++) begin
            waddr = WIN_BASE | 16'(a);
            s = '{mem_port_pkg::PORT_D, 1'b1, 1'b0, waddr, fill_word(waddr), 4'd0};
            issue(s);
        end

        for (int r = 0; r < 200; r++) begin
            draw_bits(1, b_port);
            draw_bits(1, b_wr);
            draw_bits(6, b_addr);
            draw_bits(16, b_data);
            draw_bits(2, b_hold);
            s.port  = b_port[0] ? mem_port_pkg::PORT_D : mem_port_pkg::PORT_I;
            s.write = b_port[0] & b_wr[0];
            s.pair  = 1'b0;
            s.addr  = WIN_BASE | {10'd0, b_addr[5:0]};
            s.data  = b_data;
            s.hold  = {2'b00, b_hold[1:0]};
            issue(s);
        end

        waited = 0;
        while (exp_q.size() != 0) begin
            if (waited > ACCEPT_TIMEOUT) begin
                fail_plain("responses still outstanding at the end of the test");
            end
            @(negedge clk);
            waited++;
        end

        if (errors == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            stop_run();
        end
    end

endmodule

// ==== cache_to_mem_checker.sv ====
// concurrent checks on the cache to memory top level, bound into every cache_to_mem
// read latency taken from MEM_LATENCY, checks are off while rst_n is low
`timescale 1ns/1ps
`include "mem_macros.svh"

module cache_to_mem_checker (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    i_req_valid,
    input logic                    i_req_ready,
    input logic                    d_req_valid,
    input logic                    d_req_ready,
    input mem_bus_pkg::cache_req_t d_req,
    input logic                    i_rsp_valid,
    input logic                    d_rsp_valid
);

    logic rd_acc;

    // any read accepted on this edge, either port
    assign rd_acc = (d_req_valid && d_req_ready && !d_req.write) ||
                    (i_req_valid && i_req_ready);

    // shared data bus, only one owner at a time
    a_one_owner: assert property (@(posedge clk) disable iff (!rst_n)
        !(i_rsp_valid && d_rsp_valid))
        else $error("both response valids high");

    a_rsp_has_read: assert property (@(posedge clk) disable iff (!rst_n)
        (i_rsp_valid || d_rsp_valid) |-> $past(rd_acc, `MEM_LATENCY))
        else $error("response valid without a read accepted MEM_LATENCY edges earlier");

    // data cache priority
    a_d_blocks_i: assert property (@(posedge clk) disable iff (!rst_n)
        d_req_valid |-> !i_req_ready)
        else $error("instruction port ready while a data request is pending");

endmodule

bind cache_to_mem cache_to_mem_checker u_checker (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_req_valid (i_req_valid),
    .i_req_ready (i_req_ready),
    .d_req_valid (d_req_valid),
    .d_req_ready (d_req_ready),
    .d_req       (d_req),
    .i_rsp_valid (i_rsp_valid),
    .d_rsp_valid (d_rsp_valid)
);

// ==== cache_to_mem.sv ====
// instruction and data cache sharing one fixed latency memory
// data cache has priority, rsp_data is shared and qualified by the two valids
// write address selection and miss handling stay in the caches
`timescale 1ns/1ps
`include "mem_macros.svh"

module cache_to_mem (
    input  logic                    clk,
    input  logic                    rst_n,
    // instruction cache, read only
    input  logic                    i_req_valid,
    output logic                    i_req_ready,
    input  logic [`MEM_ADDR_W-1:0]  i_addr,
    // data cache
    input  logic                    d_req_valid,
    output logic                    d_req_ready,
    input  mem_bus_pkg::cache_req_t d_req,
    // responses, no ready on this side
    output logic                    i_rsp_valid,
    output logic                    d_rsp_valid,
    output logic [`MEM_DATA_W-1:0]  rsp_data
);

    mem_bus_pkg::mem_req_t mem_req;
    logic                  rd_valid;

    mem_arbiter u_arbiter (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_req_valid (i_req_valid),
        .i_addr      (i_addr),
        .d_req_valid (d_req_valid),
        .d_req       (d_req),
        .i_req_ready (i_req_ready),
        .d_req_ready (d_req_ready),
        .mem_req     (mem_req)
    );

    mem_bank_4c #(
        .DEPTH_W (`MEM_DEPTH_W)
    ) u_bank (
        .clk      (clk),
        .rst_n    (rst_n),
        .mem_req  (mem_req),
        .rd_valid (rd_valid),
        .rd_data  (rsp_data)
    );

    // same request feeds the owner pipe so both stay in step
    mem_rsp_router u_router (
        .clk         (clk),
        .rst_n       (rst_n),
        .mem_req     (mem_req),
        .rd_valid    (rd_valid),
        .i_rsp_valid (i_rsp_valid),
        .d_rsp_valid (d_rsp_valid)
    );

endmodule

// ==== mem_rsp_router.sv ====
// steers the shared read valid to the cache that issued the read
// owner pipe has MEM_LATENCY stages to stay aligned with mem_bank_4c
// no back-pressure, a cache must take its response in that cycle
`timescale 1ns/1ps
`include "mem_macros.svh"

module mem_rsp_router (
    input  logic                  clk,
    input  logic                  rst_n,
    input  mem_bus_pkg::mem_req_t mem_req,
    input  logic                  rd_valid,
    output logic                  i_rsp_valid,
    output logic                  d_rsp_valid
);

    localparam int LAT = `MEM_LATENCY;

    mem_port_pkg::port_id_e owner_pipe [LAT];
    mem_port_pkg::port_id_e owner_in;
    mem_port_pkg::port_id_e owner_out;

    // writes and idle cycles carry no owner, they produce no response
    assign owner_in = (mem_req.enable && !mem_req.write) ? mem_req.owner
                                                         : mem_port_pkg::PORT_NONE;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < LAT; i++) begin
                owner_pipe[i] <= mem_port_pkg::PORT_NONE;
            end
        end else begin
            owner_pipe[0] <= owner_in;
            for (int i = 1; i < LAT; i++) begin
                owner_pipe[i] <= owner_pipe[i-1];
            end
        end
    end

    // last stage lines up with rd_valid from the bank
    assign owner_out = owner_pipe[LAT-1];

    assign i_rsp_valid = rd_valid && (owner_out == mem_port_pkg::PORT_I);
    assign d_rsp_valid = rd_valid && (owner_out == mem_port_pkg::PORT_D);

endmodule

// ==== mem_bank_4c.sv ====
// pipelined word memory, one request per cycle, reads return MEM_LATENCY later
// a read enabled at edge N shows rd_valid from edge N+3, sampled at edge N+4
// contents are not cleared by reset, only the pipe valids are
`timescale 1ns/1ps
`include "mem_macros.svh"

module mem_bank_4c #(
    parameter int DEPTH_W = `MEM_DEPTH_W
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  mem_bus_pkg::mem_req_t mem_req,
    output logic                  rd_valid,
    output logic [15:0]           rd_data
);

    localparam int LAT = `MEM_LATENCY;

    logic [`MEM_DATA_W-1:0] mem [1 << DEPTH_W];
    logic [LAT-1:0]         vld_pipe;
    logic [`MEM_DATA_W-1:0] data_pipe [LAT];
    logic [DEPTH_W-1:0]     idx;
    logic                   wr_en;
    logic                   rd_en;

    // upper address bits are dropped, memory aliases above 2**DEPTH_W
    assign idx   = mem_req.addr[DEPTH_W-1:0];
    assign wr_en = mem_req.enable && mem_req.write;
    assign rd_en = mem_req.enable && !mem_req.write;

    // write lands at the accepting edge, next read sees it
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[idx] <= mem_req.wdata;
        end
    end

    // valid shift pipe, one bit per read in flight
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe <= {vld_pipe[LAT-2:0], rd_en};
        end
    end

    // data pipe follows the valids, stage 0 holds the array read
    always_ff @(posedge clk) begin
        if (rd_en) begin
            data_pipe[0] <= mem[idx];
        end
        for (int i = 1; i < LAT; i++) begin
            data_pipe[i] <= data_pipe[i-1];
        end
    end

    assign rd_valid = vld_pipe[LAT-1];
    // shared by both caches, only the matching valid tells who takes it
    assign rd_data  = data_pipe[LAT-1];

endmodule

// ==== mem_arbiter.sv ====
// fixed priority arbiter, data cache always wins over instruction cache
// no fairness, the instruction port starves while d_req_valid stays high
// readies stay low during reset and for one cycle after it is released
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   i_req_valid,
    input  logic [15:0]            i_addr,
    input  logic                   d_req_valid,
    input  mem_bus_pkg::cache_req_t d_req,
    output logic                   i_req_ready,
    output logic                   d_req_ready,
    output mem_bus_pkg::mem_req_t  mem_req
);

    // design counts as running from the first edge that sees rst_n high
    logic run_q;
    logic d_acc;
    logic i_acc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
        end
    end

    // data side is never held off once running
    assign d_req_ready = rst_n && run_q;
    // instruction side waits while any data request is pending
    assign i_req_ready = rst_n && run_q && !d_req_valid;

    assign d_acc = d_req_valid && d_req_ready;
    assign i_acc = i_req_valid && i_req_ready;

    always_comb begin
        mem_req = '0;
        mem_req.owner = mem_port_pkg::PORT_NONE;
        if (d_acc) begin
            mem_req.enable = 1'b1;
            mem_req.write  = d_req.write;
            mem_req.addr   = d_req.addr;
            mem_req.wdata  = d_req.wdata;
            mem_req.owner  = mem_port_pkg::PORT_D;
        end else if (i_acc) begin
            // instruction fetch, never a write
            mem_req.enable = 1'b1;
            mem_req.addr   = i_addr;
            mem_req.owner  = mem_port_pkg::PORT_I;
        end
    end

endmodule

// ==== mem_bus_pkg.sv ====
// bus transaction types between the caches and the memory
// mem_bus_pkg refers to mem_port_pkg, so compile that one first
`include "mem_macros.svh"

package mem_bus_pkg;

    // request from one cache
    // the instruction cache only reads, so its write bit is always 0
    typedef struct packed {
        logic                   write;
        logic [`MEM_ADDR_W-1:0] addr;
        logic [`MEM_DATA_W-1:0] wdata;
    } cache_req_t;

    // request after arbitration, as the bank and the router see it
    typedef struct packed {
        // high only for a request that was accepted this cycle
        logic                   enable;
        logic                   write;
        logic [`MEM_ADDR_W-1:0] addr;
        logic [`MEM_DATA_W-1:0] wdata;
        // winner of the arbitration, PORT_NONE when idle
        mem_port_pkg::port_id_e owner;
    } mem_req_t;

endpackage

// ==== mem_port_pkg.sv ====
// requester identity shared by arbiter, router and checker
// encoding follows the older two-bit owner code, 0 means no owner
package mem_port_pkg;

    // owner of a transaction on the shared memory
    typedef enum logic [1:0] {
        PORT_NONE = 2'd0,
        // instruction cache, read only
        PORT_I    = 2'd1,
        // data cache, reads and writes
        PORT_D    = 2'd2
    } port_id_e;

endpackage

// ==== mem_macros.svh ====
// shared widths and latency for the cache to memory path
// the owner pipe and the memory bank both read MEM_LATENCY, so change it here only
// addresses are word addresses; bits above MEM_DEPTH_W are not stored
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// word address width seen by both caches
`define MEM_ADDR_W 16

// data word width
`define MEM_DATA_W 16

// cycles from an accepted read to its response
`define MEM_LATENCY 4

// stored address bits by default, 1024 words
`define MEM_DEPTH_W 10

`endif
